//--- sim/golden_vectors.txt
# kind addr data strb exp  (W: exp=pslverr, R: data=read value exp=pslverr)
# P: data=pins, U: data=uart byte, I: exp=irq, O: data=gpio_o exp=gpio_oe
R 0000 00000000 0 0
R 0004 00000000 0 0
R 0010 00000000 0 0
I 0000 00000000 0 0
W 0000 000000a5 f 0
W 0004 0000003c f 0
O 0000 000000a5 0 0000003c
W 0000 1234565a 1 0
O 0000 0000005a 0 0000003c
R 0000 0000005a 0 0
R 0004 0000003c 0 0
P 0000 00000081 0 0
R 0008 00000081 0 0
R 0010 00000081 0 0
W 0010 000001ff f 0
W 000c 00000002 f 0
P 0000 00000083 0 0
I 0000 00000000 0 1
R 0010 00000002 0 0
W 0010 00000002 f 0
I 0000 00000000 0 0
W 1000 00000055 f 0
R 1004 00000001 0 0
W 1000 000000aa f 1
U 0000 00000055 0 0
W 000c 00000100 f 0
P 0000 00000000 0 0
R 0008 00000100 0 0
R 1004 00000002 0 0
I 0000 00000000 0 1
W 1004 00000002 f 0
W 0010 00000100 f 0
I 0000 00000000 0 0
R 2000 00000000 0 1
W 2000 000000ff f 1
W 3004 ffffffff f 1
R 0000 0000005a 0 0
R 000c 00000100 0 0
R 1004 00000000 0 0

//--- src.f
design/soc_pkg.sv
design/apb_if.sv
design/apb_slave_mux.sv
design/gpio_apb.sv
design/uart_tx_apb.sv
design/periph_top.sv
sim/periph_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = periph_tb
FILELIST = src.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir

//--- sim/periph_tb.sv
`timescale 1ns/100ps
`default_nettype none

module periph_tb;
  import soc_pkg::*;

  localparam int GPIO_W   = 8;
  localparam int BAUD_DIV = 4;
  localparam int CLK_NS   = 40;

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  addr_t             paddr;
  data_t             pwdata;
  strb_t             pstrb;
  data_t             prdata;
  logic              pready;
  logic              pslverr;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_oe;
  logic              uart_tx;
  logic              irq;

  int         errors;
  int         checks;
  int         n_steps;
  logic [7:0] rx_bytes[$];
  logic [7:0] kinds[$];
  addr_t      addrs[$];
  data_t      datas[$];
  strb_t      strbs[$];
  data_t      exps[$];

  periph_top periph_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .gpio_i    (gpio_in),
    .gpio_o    (gpio_out),
    .gpio_oe   (gpio_oe),
    .uart_tx_o (uart_tx),
    .irq_o     (irq)
  );

  always #(CLK_NS / 2) clk = ~clk;

  task automatic check_data(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // setup cycle, then access cycles until pready
  task automatic apb_access(input logic wr, input addr_t addr, input data_t wdata,
                            input strb_t strb, output data_t rdata, output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    pstrb   <= strb;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    // no wait states, the first access cycle completes
    check_bit($sformatf("pready on access %h", addr), pready, 1'b1);
    while (pready !== 1'b1 && waits < 16) begin
      @(negedge clk);
      waits++;
    end
    if (pready !== 1'b1) begin
      $display("APB access to %h never completed, pready stayed low", addr);
      errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // serial receiver, each bit sampled mid-bit
  initial begin
    logic [7:0] rx_byte;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (uart_tx === 1'b0) begin
        repeat (BAUD_DIV / 2) @(negedge clk);
        if (uart_tx !== 1'b0) begin
          $display("UART start bit missing at %0t ns, line went high before mid-bit", $time);
          errors++;
        end else begin
          for (int b = 0; b < 8; b++) begin
            repeat (BAUD_DIV) @(negedge clk);
            rx_byte[b] = uart_tx;
          end
          repeat (BAUD_DIV) @(negedge clk);
          check_bit("uart stop bit", uart_tx, 1'b1);
          rx_bytes.push_back(rx_byte);
        end
      end
    end
  end

  initial begin
    int         fd;
    int         rc;
    int         waits;
    string      line;
    logic [7:0] kind;
    addr_t      addr;
    data_t      data;
    strb_t      strb;
    data_t      exp;
    data_t      rdata;
    logic       err;
    clk     = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
    gpio_in = '0;
    errors  = 0;
    checks  = 0;
    n_steps = 0;
    fd = $fopen("sim/golden_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/golden_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc > 0 && line.len() > 1 && line[0] != "#") begin
          rc = $sscanf(line, "%c %h %h %h %h", kind, addr, data, strb, exp);
          if (rc == 5) begin
            kinds.push_back(kind);
            addrs.push_back(addr);
            datas.push_back(data);
            strbs.push_back(strb);
            exps.push_back(exp);
          end else begin
            $display("golden file line not understood: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
      n_steps = kinds.size();
    end

    // budget of one full frame plus slack per step
    fork
      begin
        #((n_steps + 1) * (10 * BAUD_DIV + 20) * CLK_NS);
        $display("timeout, run did not finish %0d steps in time", n_steps);
        $display("=== FAIL ===");
        $finish;
      end
    join_none

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("uart_tx_o after reset", uart_tx, 1'b1);
    check_bit("pslverr_o after reset", pslverr, 1'b0);

    for (int i = 0; i < n_steps; i++) begin
      case (kinds[i])
        "W": begin
          apb_access(1'b1, addrs[i], datas[i], strbs[i], rdata, err);
          check_bit($sformatf("pslverr on write %h", addrs[i]), err, exps[i][0]);
        end
        "R": begin
          apb_access(1'b0, addrs[i], '0, '0, rdata, err);
          check_data($sformatf("read %h", addrs[i]), rdata, datas[i]);
          check_bit($sformatf("pslverr on read %h", addrs[i]), err, exps[i][0]);
        end
        "P": begin
          @(posedge clk);
          gpio_in <= datas[i][GPIO_W-1:0];
          repeat (4) @(posedge clk);
        end
        "U": begin
          waits = 0;
          while (rx_bytes.size() == 0 && waits < 20 * BAUD_DIV) begin
            @(negedge clk);
            waits++;
          end
          if (rx_bytes.size() == 0) begin
            $display("no UART frame arrived, expected byte %h", datas[i][7:0]);
            errors++;
          end else begin
            check_byte("uart byte", rx_bytes.pop_front(), datas[i][7:0]);
          end
        end
        "I": begin
          @(negedge clk);
          check_bit("irq_o", irq, exps[i][0]);
        end
        "O": begin
          @(negedge clk);
          check_data("gpio_o", data_t'(gpio_out), datas[i]);
          check_data("gpio_oe", data_t'(gpio_oe), exps[i]);
        end
        default: begin
          $display("unknown step kind %c in golden file", kinds[i]);
          errors++;
        end
      endcase
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/periph_top.sv
`timescale 1ns/100ps
`default_nettype none

module periph_top #(
  parameter int GPIO_W   = 8,
  parameter int BAUD_DIV = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  // apb requester
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  soc_pkg::addr_t    paddr_i,
  input  soc_pkg::data_t    pwdata_i,
  input  soc_pkg::strb_t    pstrb_i,
  output soc_pkg::data_t    prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  // pads
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_oe,
  output logic              uart_tx_o,
  output logic              irq_o
);

  apb_if gpio_bus ();
  apb_if uart_bus ();

  // uart done feeds the spare gpio input
  logic uart_done;

  apb_slave_mux apb_slave_mux_inst (
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .gpio_bus  (gpio_bus.requester),
    .uart_bus  (uart_bus.requester)
  );

  gpio_apb #(
    .GPIO_W (GPIO_W)
  ) gpio_apb_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (gpio_bus.completer),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_oe     (gpio_oe),
    .uart_done_i (uart_done),
    .irq_o       (irq_o)
  );

  uart_tx_apb #(
    .BAUD_DIV (BAUD_DIV)
  ) uart_tx_apb_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (uart_bus.completer),
    .uart_tx_o   (uart_tx_o),
    .uart_done_o (uart_done)
  );

endmodule

`default_nettype wire

//--- design/uart_tx_apb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_apb #(
  parameter int BAUD_DIV = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  apb_if.completer bus,
  output logic     uart_tx_o,
  output logic     uart_done_o
);
  import soc_pkg::*;

  localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

  // stop, data lsb first, start
  logic [9:0]       shift_q;
  logic [CNT_W-1:0] baud_cnt_q;
  logic [3:0]       bit_cnt_q;
  logic             busy_q;
  logic             done_q;
  logic             wr_en;
  logic [4:0]       offset;
  logic             tx_start;
  logic             done_clr;
  logic             baud_tick;
  logic             frame_end;

  assign offset    = bus.paddr[4:0];
  assign wr_en     = bus.psel & bus.penable & bus.pwrite;
  assign tx_start  = wr_en & (offset == UART_TXDATA) & bus.pstrb[0] & ~busy_q;
  assign done_clr  = wr_en & (offset == UART_STATUS) & bus.pstrb[0]
                     & bus.pwdata[UART_DONE_BIT];
  assign baud_tick = (baud_cnt_q == CNT_W'(BAUD_DIV - 1));
  assign frame_end = busy_q & baud_tick & (bit_cnt_q == 4'd9);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shift_q    <= '1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b0;
    end else if (tx_start) begin
      shift_q    <= {1'b1, bus.pwdata[7:0], 1'b0};
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      busy_q     <= 1'b1;
    end else if (busy_q) begin
      if (baud_tick) begin
        baud_cnt_q <= '0;
        if (frame_end) begin
          // stop bit stays on the line
          busy_q <= 1'b0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
          shift_q   <= {1'b1, shift_q[9:1]};
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + CNT_W'(1);
      end
    end
  end

  // sticky done, cleared from status
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (frame_end) begin
      done_q <= 1'b1;
    end else if (done_clr) begin
      done_q <= 1'b0;
    end
  end

  always_comb begin
    bus.prdata = '0;
    if (offset == UART_STATUS) begin
      bus.prdata[UART_BUSY_BIT] = busy_q;
      bus.prdata[UART_DONE_BIT] = done_q;
    end
  end

  assign bus.pready  = 1'b1;
  // byte dropped when the transmitter is busy
  assign bus.pslverr = wr_en & (offset == UART_TXDATA) & busy_q;

  assign uart_tx_o   = shift_q[0];
  assign uart_done_o = done_q;

  // idle line is mark
  assert property (@(posedge clk) disable iff (!rst_n) !busy_q |-> uart_tx_o)
    else $error("uart_tx_apb: line low while idle");

endmodule

`default_nettype wire

//--- design/gpio_apb.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_apb #(
  parameter int GPIO_W = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  apb_if.completer          bus,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic [GPIO_W-1:0] gpio_oe,
  input  logic              uart_done_i,
  output logic              irq_o
);
  import soc_pkg::*;

  // pins plus the uart done level on the top bit
  localparam int IN_W = GPIO_W + 1;

  logic [GPIO_W-1:0] data_out_q;
  logic [GPIO_W-1:0] out_en_q;
  logic [IN_W-1:0]   irq_en_q;
  logic [IN_W-1:0]   status_q;
  logic [IN_W-1:0]   sync1_q;
  logic [IN_W-1:0]   sync2_q;
  logic [IN_W-1:0]   sync_prev_q;
  logic [IN_W-1:0]   rise;
  logic [IN_W-1:0]   clr_mask;
  logic              wr_en;
  logic [4:0]        offset;
  data_t             merged_out;
  data_t             merged_oe;
  data_t             merged_ie;
  data_t             merged_clr;

  // byte lanes with a strobe take the new data
  function automatic data_t strb_merge(data_t old_val, data_t new_val, strb_t strb);
    data_t res;
    res = old_val;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign offset = bus.paddr[4:0];
  assign wr_en  = bus.psel & bus.penable & bus.pwrite;

  assign merged_out = strb_merge(data_t'(data_out_q), bus.pwdata, bus.pstrb);
  assign merged_oe  = strb_merge(data_t'(out_en_q), bus.pwdata, bus.pstrb);
  assign merged_ie  = strb_merge(data_t'(irq_en_q), bus.pwdata, bus.pstrb);
  assign merged_clr = strb_merge('0, bus.pwdata, bus.pstrb);

  // write one to clear
  assign clr_mask = (wr_en && offset == GPIO_IRQ_STATUS) ? merged_clr[IN_W-1:0] : '0;

  // rising edge after the synchronizer
  assign rise = sync2_q & ~sync_prev_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_out_q  <= '0;
      out_en_q    <= '0;
      irq_en_q    <= '0;
      status_q    <= '0;
      sync1_q     <= '0;
      sync2_q     <= '0;
      sync_prev_q <= '0;
    end else begin
      sync1_q     <= {uart_done_i, gpio_i};
      sync2_q     <= sync1_q;
      sync_prev_q <= sync2_q;
      // a new edge wins over a clear in the same cycle
      status_q    <= (status_q & ~clr_mask) | rise;
      if (wr_en) begin
        case (offset)
          GPIO_DATA_OUT: data_out_q <= merged_out[GPIO_W-1:0];
          GPIO_OUT_EN:   out_en_q   <= merged_oe[GPIO_W-1:0];
          GPIO_IRQ_EN:   irq_en_q   <= merged_ie[IN_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // read data, unknown offsets read zero
  always_comb begin
    bus.prdata = '0;
    case (offset)
      GPIO_DATA_OUT:   bus.prdata[GPIO_W-1:0] = data_out_q;
      GPIO_OUT_EN:     bus.prdata[GPIO_W-1:0] = out_en_q;
      GPIO_DATA_IN:    bus.prdata[IN_W-1:0]   = sync2_q;
      GPIO_IRQ_EN:     bus.prdata[IN_W-1:0]   = irq_en_q;
      GPIO_IRQ_STATUS: bus.prdata[IN_W-1:0]   = status_q;
      default: ;
    endcase
  end

  assign bus.pready  = 1'b1;
  assign bus.pslverr = 1'b0;

  assign gpio_o  = data_out_q;
  assign gpio_oe = out_en_q;
  assign irq_o   = |(status_q & irq_en_q);

  // the multiplexer gates penable with the select
  assert property (@(posedge clk) disable iff (!rst_n) bus.penable |-> bus.psel)
    else $error("gpio_apb: penable without psel");

endmodule

`default_nettype wire

//--- design/apb_slave_mux.sv
`timescale 1ns/100ps
`default_nettype none

module apb_slave_mux (
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  soc_pkg::addr_t  paddr_i,
  input  soc_pkg::data_t  pwdata_i,
  input  soc_pkg::strb_t  pstrb_i,
  output soc_pkg::data_t  prdata_o,
  output logic            pready_o,
  output logic            pslverr_o,
  apb_if.requester        gpio_bus,
  apb_if.requester        uart_bus
);
  import soc_pkg::*;

  logic [3:0] region;
  logic       gpio_hit;
  logic       uart_hit;

  assign region   = paddr_i[ADDR_W-1 -: 4];
  assign gpio_hit = (region == REGION_GPIO);
  assign uart_hit = (region == REGION_UART);

  // only the addressed completer sees psel
  // penable follows it so an idle completer never sees an access phase
  assign gpio_bus.psel    = psel_i & gpio_hit;
  assign gpio_bus.penable = penable_i & gpio_hit;
  assign gpio_bus.pwrite  = pwrite_i;
  assign gpio_bus.paddr   = paddr_i;
  assign gpio_bus.pwdata  = pwdata_i;
  assign gpio_bus.pstrb   = pstrb_i;

  assign uart_bus.psel    = psel_i & uart_hit;
  assign uart_bus.penable = penable_i & uart_hit;
  assign uart_bus.pwrite  = pwrite_i;
  assign uart_bus.paddr   = paddr_i;
  assign uart_bus.pwdata  = pwdata_i;
  assign uart_bus.pstrb   = pstrb_i;

  // response from the addressed completer
  always_comb begin
    if (gpio_hit) begin
      prdata_o  = gpio_bus.prdata;
      pready_o  = gpio_bus.pready;
      pslverr_o = gpio_bus.pslverr;
    end else if (uart_hit) begin
      prdata_o  = uart_bus.prdata;
      pready_o  = uart_bus.pready;
      pslverr_o = uart_bus.pslverr;
    end else begin
      // unmapped region, error on the access phase
      prdata_o  = '0;
      pready_o  = 1'b1;
      pslverr_o = psel_i & penable_i;
    end
  end

endmodule

`default_nettype wire

//--- design/apb_if.sv
`timescale 1ns/100ps
`default_nettype none

interface apb_if;
  import soc_pkg::*;

  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  data_t pwdata;
  strb_t pstrb;
  data_t prdata;
  logic  pready;
  logic  pslverr;

  // multiplexer side
  modport requester (
    output psel, penable, pwrite, paddr, pwdata, pstrb,
    input  prdata, pready, pslverr
  );

  // peripheral side
  modport completer (
    input  psel, penable, pwrite, paddr, pwdata, pstrb,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // apb bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // region field, paddr[15:12]
  localparam logic [3:0] REGION_GPIO = 4'h0;
  localparam logic [3:0] REGION_UART = 4'h1;

  // gpio register offsets
  localparam logic [4:0] GPIO_DATA_OUT   = 5'h00;
  localparam logic [4:0] GPIO_OUT_EN     = 5'h04;
  localparam logic [4:0] GPIO_DATA_IN    = 5'h08;
  localparam logic [4:0] GPIO_IRQ_EN     = 5'h0C;
  localparam logic [4:0] GPIO_IRQ_STATUS = 5'h10;

  // uart register offsets
  localparam logic [4:0] UART_TXDATA = 5'h00;
  localparam logic [4:0] UART_STATUS = 5'h04;

  // uart status bits
  localparam int UART_BUSY_BIT = 0;
  localparam int UART_DONE_BIT = 1;

endpackage

`default_nettype wire
